//--- verilog/turbo_pkg.sv
////////////////////
// turbo and timebase package
// speed, state and register address enums
// bus widths, divider reloads, reset and suppression lengths
////////////////////

package turbo_pkg;

  // bus widths
  localparam int BUS_ADDR_W = 12;
  localparam int BUS_DATA_W = 32;

  typedef enum logic [1:0] {
    SPEED_1X   = 2'd0,
    SPEED_4X   = 2'd1,
    SPEED_50X  = 2'd2,
    SPEED_FULL = 2'd3
  } turbo_speed_e;

  typedef enum logic [1:0] {
    TURBO_OFF        = 2'd0,
    TURBO_SUPPRESSED = 2'd1,
    TURBO_ARMED      = 2'd2
  } turbo_state_e;

  // settings register map
  typedef enum logic [BUS_ADDR_W-1:0] {
    ADDR_RESET    = 12'h000,
    ADDR_SOUND    = 12'h010,
    ADDR_SPEED    = 12'h100,
    ADDR_CANCEL   = 12'h104,
    ADDR_SUPPRESS = 12'h108
  } reg_addr_e;

  ////////////////////
  // core timebase
  ////////////////////
  localparam int DIV_W = 12;
  localparam logic [DIV_W-1:0] BASE_DIV    = 12'd100;
  localparam logic [DIV_W-1:0] RELOAD_1X   = BASE_DIV;
  localparam logic [DIV_W-1:0] RELOAD_4X   = BASE_DIV / 4;
  localparam logic [DIV_W-1:0] RELOAD_50X  = BASE_DIV / 50;
  localparam logic [DIV_W-1:0] RELOAD_FULL = 12'd1;

  // reset and suppression lengths, shortened for simulation
  localparam int CORE_RESET_CYCLES = 64;
  localparam int RST_W             = $clog2(CORE_RESET_CYCLES + 1);
  localparam int SUPPRESS_TICKS    = 40;
  localparam int SUP_W             = $clog2(SUPPRESS_TICKS + 1);
  localparam int SS_RESET_TICKS    = 4;
  localparam int SS_W              = $clog2(SS_RESET_TICKS + 1);

endpackage

//--- verilog/turbo_regs.sv
////////////////////
// wishbone settings registers
// sound, speed, cancel and suppress settings, bus reset pulse
// buzzer audio gate
////////////////////

`timescale 1ns/1ps

module turbo_regs
  import turbo_pkg::*;
(
  input  logic                  clk_sys_117_964,
  input  logic                  reset_turbo_s,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [BUS_ADDR_W-1:0] wb_adr,
  input  logic [BUS_DATA_W-1:0] wb_dat_w,
  output logic [BUS_DATA_W-1:0] wb_dat_r,
  output logic                  wb_ack,
  input  logic                  turbo_cancel,
  input  logic                  buzzer,
  output turbo_speed_e          turbo_speed,
  output logic                  cancel_on_event,
  output logic                  suppress_on_activate,
  output logic                  reset_request,
  output logic                  audio_out
);

  logic disable_sound;
  logic bus_hit;
  logic bus_wr;

  // new cycle seen, ack not yet given
  assign bus_hit = wb_cyc && wb_stb && !wb_ack;
  assign bus_wr  = bus_hit && wb_we;

  ////////////////////
  // bus handshake and writes
  ////////////////////
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      wb_ack               <= 1'b0;
      reset_request        <= 1'b0;
      disable_sound        <= 1'b0;
      turbo_speed          <= SPEED_1X;
      cancel_on_event      <= 1'b0;
      suppress_on_activate <= 1'b0;
    end else begin
      wb_ack        <= bus_hit;
      reset_request <= 1'b0;

      if (bus_wr) begin
        case (wb_adr)
          ADDR_RESET:    reset_request        <= 1'b1;
          ADDR_SOUND:    disable_sound        <= wb_dat_w[0];
          ADDR_SPEED:    turbo_speed          <= turbo_speed_e'(wb_dat_w[1:0]);
          ADDR_CANCEL:   cancel_on_event      <= wb_dat_w[0];
          ADDR_SUPPRESS: suppress_on_activate <= wb_dat_w[0];
          default: begin
          end
        endcase
      end

      // a cancel from the fsm drops back to 1x
      if (turbo_cancel) begin
        turbo_speed <= SPEED_1X;
      end
    end
  end

  ////////////////////
  // read mux
  ////////////////////
  // reads the live registers, so a cancel shows up on the next read
  always_comb begin
    wb_dat_r = '0;
    case (wb_adr)
      ADDR_SOUND:    wb_dat_r[0]   = disable_sound;
      ADDR_SPEED:    wb_dat_r[1:0] = turbo_speed;
      ADDR_CANCEL:   wb_dat_r[0]   = cancel_on_event;
      ADDR_SUPPRESS: wb_dat_r[0]   = suppress_on_activate;
      default:       wb_dat_r      = '0;
    endcase
  end

  // buzzer muted when sound off or running too fast to be audible
  assign audio_out = buzzer && !disable_sound &&
                     (turbo_speed == SPEED_1X || turbo_speed == SPEED_4X);

endmodule

//--- verilog/turbo_fsm.sv
////////////////////
// turbo state machine
// activation detect, suppression countdown in core ticks
// cancel on buzzer
////////////////////

`timescale 1ns/1ps

module turbo_fsm
  import turbo_pkg::*;
(
  input  logic         clk_sys_117_964,
  input  logic         reset_turbo_s,
  input  turbo_speed_e turbo_speed,
  input  logic         cancel_on_event,
  input  logic         suppress_on_activate,
  input  logic         buzzer,
  input  logic         tick,
  output logic         turbo_cancel
);

  turbo_state_e     state;
  logic             prev_speed_zero;
  logic             speed_zero;
  logic             activated;
  logic [SUP_W-1:0] sup_cnt;

  assign speed_zero = (turbo_speed == SPEED_1X);

  // speed went from zero to non-zero
  assign activated = prev_speed_zero && !speed_zero;

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      state           <= TURBO_OFF;
      prev_speed_zero <= 1'b1;
      sup_cnt         <= '0;
      turbo_cancel    <= 1'b0;
    end else begin
      prev_speed_zero <= speed_zero;
      turbo_cancel    <= 1'b0;

      case (state)
        TURBO_OFF: begin
          if (activated) begin
            if (suppress_on_activate) begin
              state   <= TURBO_SUPPRESSED;
              sup_cnt <= SUP_W'(SUPPRESS_TICKS);
            end else begin
              state <= TURBO_ARMED;
            end
          end
        end

        // buzzer is ignored here
        TURBO_SUPPRESSED: begin
          if (speed_zero) begin
            state   <= TURBO_OFF;
            sup_cnt <= '0;
          end else if (tick) begin
            sup_cnt <= sup_cnt - 1'b1;
            if (sup_cnt == SUP_W'(1)) begin
              state <= TURBO_ARMED;
            end
          end
        end

        TURBO_ARMED: begin
          if (speed_zero) begin
            state <= TURBO_OFF;
          end else if (cancel_on_event && buzzer) begin
            turbo_cancel <= 1'b1;
            state        <= TURBO_OFF;
          end
        end

        default: begin
          state <= TURBO_OFF;
        end
      endcase
    end
  end

endmodule

//--- verilog/core_clock_div.sv
////////////////////
// core clock-enable divider
// speed-dependent reload, tick and double-rate tick
////////////////////

`timescale 1ns/1ps

module core_clock_div
  import turbo_pkg::*;
(
  input  logic         clk_sys_117_964,
  input  logic         reset_turbo_s,
  input  turbo_speed_e turbo_speed,
  input  logic         ss_halt,
  output logic         tick,
  output logic         tick_2x,
  output logic         core_clk_en,
  output logic         core_clk_2x_en
);

  logic [DIV_W-1:0] count;
  logic [DIV_W-1:0] half;
  logic [DIV_W-1:0] reload;

  // reload table
  always_comb begin
    case (turbo_speed)
      SPEED_1X:   reload = RELOAD_1X;
      SPEED_4X:   reload = RELOAD_4X;
      SPEED_50X:  reload = RELOAD_50X;
      SPEED_FULL: reload = RELOAD_FULL;
      default:    reload = RELOAD_1X;
    endcase
  end

  ////////////////////
  // down-counter
  ////////////////////
  // half point latched with the reload so a speed change
  // never skips or doubles a tick
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      count <= RELOAD_1X;
      half  <= RELOAD_1X >> 1;
    end else if (count == '0) begin
      count <= reload;
      half  <= (reload == RELOAD_FULL) ? RELOAD_FULL : (reload >> 1);
    end else begin
      count <= count - 1'b1;
    end
  end

  assign tick    = (count == '0);
  assign tick_2x = (count == '0) || (count == half);

  // savestate halt freezes the core
  assign core_clk_en    = tick && !ss_halt;
  assign core_clk_2x_en = tick_2x && !ss_halt;

endmodule

//--- verilog/core_reset_gen.sv
////////////////////
// core reset generator
// timed bus reset, savestate reset in double-rate ticks
////////////////////

`timescale 1ns/1ps

module core_reset_gen
  import turbo_pkg::*;
(
  input  logic clk_sys_117_964,
  input  logic reset_turbo_s,
  input  logic reset_request,
  input  logic ss_begin_reset,
  input  logic tick_2x,
  output logic core_reset
);

  logic [RST_W-1:0] bus_cnt;
  logic [SS_W-1:0]  ss_cnt;

  // bus-requested reset counts system cycles
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      bus_cnt <= '0;
    end else if (reset_request) begin
      bus_cnt <= RST_W'(CORE_RESET_CYCLES);
    end else if (bus_cnt != '0) begin
      bus_cnt <= bus_cnt - 1'b1;
    end
  end

  // savestate reset counts tick_2x pulses, so its length depends on speed
  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      ss_cnt <= '0;
    end else if (ss_begin_reset) begin
      ss_cnt <= SS_W'(SS_RESET_TICKS);
    end else if (ss_cnt != '0 && tick_2x) begin
      ss_cnt <= ss_cnt - 1'b1;
    end
  end

  assign core_reset = (bus_cnt != '0) || (ss_cnt != '0);

endmodule

//--- verilog/turbo_core_top.sv
////////////////////
// turbo and timebase top level
// settings, divider, turbo fsm, reset generator
////////////////////

`timescale 1ns/1ps

module turbo_core_top
  import turbo_pkg::*;
(
  input  logic                  clk_sys_117_964,
  input  logic                  reset_turbo_s,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [BUS_ADDR_W-1:0] wb_adr,
  input  logic [BUS_DATA_W-1:0] wb_dat_w,
  output logic [BUS_DATA_W-1:0] wb_dat_r,
  output logic                  wb_ack,
  input  logic                  buzzer,
  input  logic                  ss_halt,
  input  logic                  ss_begin_reset,
  output logic                  core_clk_en,
  output logic                  core_clk_2x_en,
  output logic                  core_reset,
  output logic                  audio_out
);

  turbo_speed_e turbo_speed;
  logic         cancel_on_event;
  logic         suppress_on_activate;
  logic         reset_request;
  logic         turbo_cancel;
  logic         tick;
  logic         tick_2x;

  turbo_regs turbo_core_regs (
    .clk_sys_117_964     (clk_sys_117_964),
    .reset_turbo_s       (reset_turbo_s),
    .wb_cyc              (wb_cyc),
    .wb_stb              (wb_stb),
    .wb_we               (wb_we),
    .wb_adr              (wb_adr),
    .wb_dat_w            (wb_dat_w),
    .wb_dat_r            (wb_dat_r),
    .wb_ack              (wb_ack),
    .turbo_cancel        (turbo_cancel),
    .buzzer              (buzzer),
    .turbo_speed         (turbo_speed),
    .cancel_on_event     (cancel_on_event),
    .suppress_on_activate(suppress_on_activate),
    .reset_request       (reset_request),
    .audio_out           (audio_out)
  );

  core_clock_div turbo_core_div (
    .clk_sys_117_964(clk_sys_117_964),
    .reset_turbo_s  (reset_turbo_s),
    .turbo_speed    (turbo_speed),
    .ss_halt        (ss_halt),
    .tick           (tick),
    .tick_2x        (tick_2x),
    .core_clk_en    (core_clk_en),
    .core_clk_2x_en (core_clk_2x_en)
  );

  turbo_fsm turbo_core_fsm (
    .clk_sys_117_964     (clk_sys_117_964),
    .reset_turbo_s       (reset_turbo_s),
    .turbo_speed         (turbo_speed),
    .cancel_on_event     (cancel_on_event),
    .suppress_on_activate(suppress_on_activate),
    .buzzer              (buzzer),
    .tick                (tick),
    .turbo_cancel        (turbo_cancel)
  );

  core_reset_gen turbo_core_rst (
    .clk_sys_117_964(clk_sys_117_964),
    .reset_turbo_s  (reset_turbo_s),
    .reset_request  (reset_request),
    .ss_begin_reset (ss_begin_reset),
    .tick_2x        (tick_2x),
    .core_reset     (core_reset)
  );

endmodule

//--- tb/turbo_core_checker.sv
////////////////////
// bound assertions on the top level
// wishbone ack rule, turbo cancel, tick spacing
////////////////////

`timescale 1ns/1ps

module turbo_core_checker
  import turbo_pkg::*;
(
  input logic         clk_sys_117_964,
  input logic         reset_turbo_s,
  input logic         wb_cyc,
  input logic         wb_stb,
  input logic         wb_ack,
  input logic         turbo_cancel,
  input turbo_speed_e turbo_speed,
  input logic         tick
);

  int fail_count = 0;

  // ack only inside an active bus cycle
  ack_in_cycle: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    wb_ack |-> (wb_cyc && wb_stb))
    else begin
      fail_count++;
      $error("wb_ack outside wb_cyc and wb_stb");
    end

  // a cancel from the fsm drops the speed register back to 1x
  cancel_to_1x: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    turbo_cancel |=> (turbo_speed == SPEED_1X))
    else begin
      fail_count++;
      $error("turbo_speed not back to 1x after turbo_cancel");
    end

  // shortest period is two cycles
  tick_spaced: assert property (@(posedge clk_sys_117_964) disable iff (reset_turbo_s)
    tick |=> !tick)
    else begin
      fail_count++;
      $error("tick high in two consecutive cycles");
    end

endmodule

bind turbo_core_top turbo_core_checker turbo_core_checks (
  .clk_sys_117_964(clk_sys_117_964),
  .reset_turbo_s  (reset_turbo_s),
  .wb_cyc         (wb_cyc),
  .wb_stb         (wb_stb),
  .wb_ack         (wb_ack),
  .turbo_cancel   (turbo_cancel),
  .turbo_speed    (turbo_speed),
  .tick           (tick)
);

//--- tb/turbo_core_tb.sv
////////////////////
// testbench for the turbo and timebase top level
// settings readback, divider, turbo cancel, audio gate, resets
////////////////////

`timescale 1ns/1ps

module turbo_core_tb
  import turbo_pkg::*;
();

  // twice the estimated length of all tests
  localparam int MAX_CYCLES = 2 * (4 * 8 * (int'(BASE_DIV) + 1) +
    (SUPPRESS_TICKS + 8) * (int'(BASE_DIV) / 4 + 1) + 2 * CORE_RESET_CYCLES + 1000);

  logic                  clk_sys_117_964;
  logic                  reset_turbo_s;
  logic                  wb_cyc, wb_stb, wb_we;
  logic [BUS_ADDR_W-1:0] wb_adr;
  logic [BUS_DATA_W-1:0] wb_dat_w, wb_dat_r, rdata;
  logic                  wb_ack, buzzer, ss_halt, ss_begin_reset;
  logic                  core_clk_en, core_clk_2x_en, core_reset, audio_out;
  logic [31:0]           rng = 32'd3316;
  logic                  audio_chk_en = 1'b0;
  logic                  exp_sound_dis = 1'b0;
  turbo_speed_e          exp_speed = SPEED_1X;
  int                    value_errs = 0;
  int                    other_errs = 0;
  int                    cycle_cnt = 0;

  turbo_core_top turbo_core_top_inst (.*);

  always #20 clk_sys_117_964 = ~clk_sys_117_964;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  ////////////////////
  // reference model
  ////////////////////
  function automatic int ref_reload(input turbo_speed_e sp);
    case (sp)
      SPEED_1X:  return int'(BASE_DIV);
      SPEED_4X:  return int'(BASE_DIV) / 4;
      SPEED_50X: return int'(BASE_DIV) / 50;
      default:   return 1;
    endcase
  endfunction

  // buzzer forced low with sound off or at 50x and full speed
  function automatic logic ref_audio(input logic b, input logic dis, input turbo_speed_e sp);
    if (dis || sp == SPEED_50X || sp == SPEED_FULL) begin
      return 1'b0;
    end
    return b;
  endfunction

  task automatic check_speed(input turbo_speed_e got, input turbo_speed_e exp, input string name);
    if (got !== exp) begin
      value_errs++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_data(input logic [BUS_DATA_W-1:0] got, input logic [BUS_DATA_W-1:0] exp,
                            input string name);
    if (got !== exp) begin
      value_errs++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      value_errs++;
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  ////////////////////
  // bus and timing helpers
  ////////////////////
  task automatic bus_cycle(input logic we, input logic [BUS_ADDR_W-1:0] addr,
                           input logic [BUS_DATA_W-1:0] data);
    int n;
    n = 0;
    @(posedge clk_sys_117_964);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= addr;
    wb_dat_w <= data;
    do begin
      @(negedge clk_sys_117_964);
      n++;
    end while (!wb_ack && n < 16);
    if (!wb_ack) begin
      other_errs++;
      $display("no wb_ack within 16 cycles at address 0x%h", addr);
    end
    rdata = wb_dat_r;
    @(posedge clk_sys_117_964);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [BUS_ADDR_W-1:0] addr, input logic [BUS_DATA_W-1:0] data);
    bus_cycle(1'b1, addr, data);
  endtask

  task automatic wb_read(input logic [BUS_ADDR_W-1:0] addr);
    bus_cycle(1'b0, addr, '0);
  endtask

  task automatic pulse_buzzer();
    @(posedge clk_sys_117_964);
    buzzer <= 1'b1;
    @(posedge clk_sys_117_964);
    buzzer <= 1'b0;
  endtask

  task automatic wait_ticks(input int n);
    repeat (n) begin
      @(negedge clk_sys_117_964);
      while (!core_clk_en) @(negedge clk_sys_117_964);
    end
  endtask

  // cycles from one core_clk_en to the next, and 2x pulses in between
  task automatic measure_period(output int spacing, output int n2x);
    wait_ticks(1);
    spacing = 0;
    n2x = 0;
    do begin
      @(negedge clk_sys_117_964);
      spacing++;
      if (core_clk_2x_en) n2x++;
    end while (!core_clk_en);
  endtask

  // audio gate compare
  always @(negedge clk_sys_117_964) begin
    if (audio_chk_en) begin
      check_bit(audio_out, ref_audio(buzzer, exp_sound_dis, exp_speed), "audio_out");
    end
  end

  always @(posedge clk_sys_117_964) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("run did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs + 1);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int                    sp_i;
    int                    spacing;
    int                    n2x;
    int                    len;
    logic [BUS_ADDR_W-1:0] addr;
    turbo_speed_e          sp;
    clk_sys_117_964 = 1'b0;
    reset_turbo_s   = 1'b1;
    wb_cyc          = 1'b0;
    wb_stb          = 1'b0;
    wb_we           = 1'b0;
    wb_adr          = '0;
    wb_dat_w        = '0;
    buzzer          = 1'b0;
    ss_halt         = 1'b0;
    ss_begin_reset  = 1'b0;
    repeat (8) @(posedge clk_sys_117_964);
    reset_turbo_s <= 1'b0;
    @(negedge clk_sys_117_964);
    check_data(BUS_DATA_W'({wb_ack, core_reset, core_clk_en, core_clk_2x_en}), '0,
               "outputs after reset");

    // random settings read back
    repeat (8) begin
      rng = xorshift32(rng);
      case (rng[1:0])
        2'd0:    addr = ADDR_SOUND;
        2'd1:    addr = ADDR_CANCEL;
        2'd2:    addr = ADDR_SUPPRESS;
        default: addr = ADDR_SPEED;
      endcase
      rng = xorshift32(rng);
      wb_write(addr, rng);
      wb_read(addr);
      check_data(rdata, (addr == ADDR_SPEED) ? {30'd0, rng[1:0]} : {31'd0, rng[0]}, "wb_dat_r");
    end
    wb_read(12'h004);
    check_data(rdata, '0, "wb_dat_r unlisted");
    wb_read(ADDR_RESET);
    check_data(rdata, '0, "wb_dat_r reset");

    ////////////////////
    // divider per speed
    ////////////////////
    wb_write(ADDR_CANCEL, 0);
    wb_write(ADDR_SUPPRESS, 0);
    for (sp_i = 0; sp_i < 4; sp_i++) begin
      sp = turbo_speed_e'(sp_i);
      wb_write(ADDR_SPEED, sp_i);
      measure_period(spacing, n2x);
      measure_period(spacing, n2x);
      measure_period(spacing, n2x);
      check_data(spacing, ref_reload(sp) + 1, "core_clk_en spacing");
      // at full speed the 2x enable is high every cycle
      check_data(n2x, (sp == SPEED_FULL) ? ref_reload(sp) + 1 : 2, "core_clk_2x_en count");
      @(posedge clk_sys_117_964);
      ss_halt <= 1'b1;
      len = 0;
      repeat (2 * ref_reload(sp) + 4) begin
        @(negedge clk_sys_117_964);
        if (core_clk_en || core_clk_2x_en) len++;
      end
      check_data(len, 0, "enables while halted");
      @(posedge clk_sys_117_964);
      ss_halt <= 1'b0;
    end

    // cancel on buzzer, no suppression
    wb_write(ADDR_SPEED, 0);
    wb_write(ADDR_CANCEL, 1);
    wb_write(ADDR_SPEED, SPEED_50X);
    pulse_buzzer();
    wb_read(ADDR_SPEED);
    check_speed(turbo_speed_e'(rdata[1:0]), SPEED_1X, "turbo_speed after buzzer");

    // suppression window
    wb_write(ADDR_SPEED, 0);
    wb_write(ADDR_SUPPRESS, 1);
    wb_write(ADDR_SPEED, SPEED_4X);
    wait_ticks(5);
    pulse_buzzer();
    wb_read(ADDR_SPEED);
    check_speed(turbo_speed_e'(rdata[1:0]), SPEED_4X, "turbo_speed while suppressed");
    wait_ticks(SUPPRESS_TICKS);
    pulse_buzzer();
    wb_read(ADDR_SPEED);
    check_speed(turbo_speed_e'(rdata[1:0]), SPEED_1X, "turbo_speed after suppression");

    ////////////////////
    // audio gate
    ////////////////////
    wb_write(ADDR_CANCEL, 0);
    for (sp_i = 0; sp_i < 8; sp_i++) begin
      exp_speed     = turbo_speed_e'(sp_i[1:0]);
      exp_sound_dis = sp_i[2];
      wb_write(ADDR_SOUND, exp_sound_dis);
      wb_write(ADDR_SPEED, exp_speed);
      audio_chk_en = 1'b1;
      repeat (16) begin
        @(posedge clk_sys_117_964);
        rng = xorshift32(rng);
        buzzer <= rng[0];
      end
      @(posedge clk_sys_117_964);
      buzzer <= 1'b0;
      audio_chk_en = 1'b0;
    end

    // bus reset length, then savestate reset in 2x ticks
    wb_write(ADDR_RESET, 1);
    @(negedge clk_sys_117_964);
    while (!core_reset) @(negedge clk_sys_117_964);
    len = 0;
    while (core_reset) begin
      len++;
      @(negedge clk_sys_117_964);
    end
    check_data(len, CORE_RESET_CYCLES, "core_reset length");
    wb_write(ADDR_SPEED, SPEED_4X);
    @(posedge clk_sys_117_964);
    ss_begin_reset <= 1'b1;
    @(posedge clk_sys_117_964);
    ss_begin_reset <= 1'b0;
    n2x = 0;
    @(negedge clk_sys_117_964);
    while (core_reset) begin
      if (core_clk_2x_en) n2x++;
      @(negedge clk_sys_117_964);
    end
    check_data(n2x, SS_RESET_TICKS, "core_clk_2x_en pulses in savestate reset");

    other_errs += turbo_core_top_inst.turbo_core_checks.fail_count;
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- all.f
verilog/turbo_pkg.sv
verilog/turbo_regs.sv
verilog/turbo_fsm.sv
verilog/core_clock_div.sv
verilog/core_reset_gen.sv
verilog/turbo_core_top.sv
tb/turbo_core_checker.sv
tb/turbo_core_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = turbo_core_tb
FILELIST = all.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
